// File: design/dispatch_pkg.sv
/*
 * Shared widths and sizes for the thread-block dispatch subsystem.
 * Imported by every RTL block and by the testbench.
 */
package dispatch_pkg;

    // ########################################
    // Request fields
    // ########################################

    // Program counter of the kernel entry point
    localparam int unsigned PC_W = 16;

    // Data / parameter address handed to every block
    localparam int unsigned ADDR_W = 32;

    // Block index inside a group
    // Also the width of the block count of a request
    localparam int unsigned TBLOCK_IDX_W = 8;

    // Group id shared by all blocks of one request
    localparam int unsigned TBLOCK_ID_W = 8;

    // ########################################
    // Compute clusters
    // ########################################

    // Warp slots in one cluster
    localparam int unsigned WARPS_PER_CLUSTER = 4;

    // Slot index width
    // Follows the number of slots per cluster
    localparam int unsigned SLOT_W = $clog2(WARPS_PER_CLUSTER);

endpackage : dispatch_pkg

// File: design/thread_dispatcher.sv
/*
 * Holds one kernel launch request and hands out its thread blocks one index per cycle.
 * Block 0 goes out combinationally in the start cycle when a warp slot is free.
 */
`timescale 1ns/1ps

module thread_dispatcher (
    // Clock and reset
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    // Launch request from the host
    output logic                                ready_o,
    input  logic                                start_i,
    input  logic [dispatch_pkg::PC_W-1:0]         pc_i,
    input  logic [dispatch_pkg::ADDR_W-1:0]       dp_addr_i,
    input  logic [dispatch_pkg::TBLOCK_IDX_W-1:0] number_of_tblocks_i,
    input  logic [dispatch_pkg::TBLOCK_ID_W-1:0]  tblock_id_i,

    // Block allocation towards the cluster selector
    input  logic                                warp_free_i,
    output logic                                allocate_warp_o,
    output logic [dispatch_pkg::PC_W-1:0]         allocate_pc_o,
    output logic [dispatch_pkg::ADDR_W-1:0]       allocate_dp_addr_o,
    output logic [dispatch_pkg::TBLOCK_IDX_W-1:0] allocate_tblock_idx_o,
    output logic [dispatch_pkg::TBLOCK_ID_W-1:0]  allocate_tblock_id_o
);

    import dispatch_pkg::*;

    // ########################################
    // Signals
    // ########################################

    // Stored request fields
    logic [PC_W-1:0]         pc_q;
    logic [PC_W-1:0]         pc_d;
    logic [ADDR_W-1:0]       dp_addr_q;
    logic [ADDR_W-1:0]       dp_addr_d;
    logic [TBLOCK_ID_W-1:0]  tblock_id_q;
    logic [TBLOCK_ID_W-1:0]  tblock_id_d;

    // Block count of the request and blocks handed out so far
    logic [TBLOCK_IDX_W-1:0] count_q;
    logic [TBLOCK_IDX_W-1:0] count_d;
    logic [TBLOCK_IDX_W-1:0] dispatched_q;
    logic [TBLOCK_IDX_W-1:0] dispatched_d;

    // No block of the current request left to hand out
    logic                    idle;

    // ########################################
    // Combinational logic
    // ########################################

    assign idle = (dispatched_q == count_q);

    always_comb begin : dispatch_logic
        // Hold state by default
        pc_d         = pc_q;
        dp_addr_d    = dp_addr_q;
        tblock_id_d  = tblock_id_q;
        count_d      = count_q;
        dispatched_d = dispatched_q;

        // Nothing presented by default
        ready_o               = idle;
        allocate_warp_o       = 1'b0;
        allocate_pc_o         = '0;
        allocate_dp_addr_o    = '0;
        allocate_tblock_idx_o = '0;
        allocate_tblock_id_o  = '0;

        if (idle) begin : accept_request
            if (start_i) begin : start_request
                // Capture the request
                pc_d         = pc_i;
                dp_addr_d    = dp_addr_i;
                tblock_id_d  = tblock_id_i;
                count_d      = number_of_tblocks_i;
                dispatched_d = '0;

                // A zero-count request stays idle and presents nothing
                if (number_of_tblocks_i != '0) begin : first_block
                    // Block 0 straight from the request inputs
                    allocate_warp_o       = 1'b1;
                    allocate_pc_o         = pc_i;
                    allocate_dp_addr_o    = dp_addr_i;
                    allocate_tblock_idx_o = '0;
                    allocate_tblock_id_o  = tblock_id_i;

                    if (warp_free_i) begin : first_taken
                        dispatched_d = TBLOCK_IDX_W'(1);
                    end : first_taken
                end : first_block
            end : start_request
        end : accept_request
        else begin : next_block
            // Stored fields with the running count as block index
            allocate_warp_o       = 1'b1;
            allocate_pc_o         = pc_q;
            allocate_dp_addr_o    = dp_addr_q;
            allocate_tblock_idx_o = dispatched_q;
            allocate_tblock_id_o  = tblock_id_q;

            // Advance only when a slot takes the block
            // Otherwise index and fields hold
            if (warp_free_i) begin : block_taken
                dispatched_d = dispatched_q + TBLOCK_IDX_W'(1);
            end : block_taken
        end : next_block
    end : dispatch_logic

    // ########################################
    // Sequential logic
    // ########################################

    // Progress counters
    always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_regs
        if (!rst_n_i) begin
            count_q      <= '0;
            dispatched_q <= '0;
        end else begin
            count_q      <= count_d;
            dispatched_q <= dispatched_d;
        end
    end : ctrl_regs

    // Request payload
    always_ff @(posedge clk_i) begin : payload_regs
        pc_q        <= pc_d;
        dp_addr_q   <= dp_addr_d;
        tblock_id_q <= tblock_id_d;
    end : payload_regs

endmodule : thread_dispatcher

// File: design/warp_pool.sv
/*
 * Busy-slot table of one compute cluster.
 * Offers its lowest free slot, reserves it on a grant and frees slots on done pulses.
 */
`timescale 1ns/1ps

module warp_pool (
    // Clock and reset
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    // Reservation of the offered slot
    input  logic                          grant_i,

    // Warp completion from the cluster
    input  logic                          done_i,
    input  logic [dispatch_pkg::SLOT_W-1:0] done_slot_i,

    // Free status towards the cluster selector
    output logic                          free_o,
    output logic [dispatch_pkg::SLOT_W-1:0] slot_o
);

    import dispatch_pkg::*;

    // ########################################
    // Signals
    // ########################################

    // One bit per warp slot, set while a block occupies it
    logic [WARPS_PER_CLUSTER-1:0] busy_q;
    logic [WARPS_PER_CLUSTER-1:0] busy_d;

    // ########################################
    // Lowest free slot
    // ########################################

    // Search from the top so the lowest clear bit wins
    always_comb begin : free_search
        free_o = 1'b0;
        slot_o = '0;
        for (int i = WARPS_PER_CLUSTER - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_o = 1'b1;
                slot_o = SLOT_W'(i);
            end
        end
    end : free_search

    // ########################################
    // Busy table update
    // ########################################

    always_comb begin : busy_update
        busy_d = busy_q;

        // Done on an idle slot clears nothing new
        if (done_i) begin
            busy_d[done_slot_i] = 1'b0;
        end

        // Offered slot is free, so a set here never loses a pending done
        if (grant_i) begin
            busy_d[slot_o] = 1'b1;
        end
    end : busy_update

    // All slots free after reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin : busy_reg
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end : busy_reg

endmodule : warp_pool

// File: design/cluster_select.sv
/*
 * Round-robin choice between the two warp pools.
 * Merges their free status for the dispatcher and routes each grant to one pool.
 */
`timescale 1ns/1ps

module cluster_select (
    // Clock and reset
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    // Block presented by the dispatcher
    input  logic                          allocate_i,

    // Free status of cluster 0
    input  logic                          free0_i,
    input  logic [dispatch_pkg::SLOT_W-1:0] slot0_i,

    // Free status of cluster 1
    input  logic                          free1_i,
    input  logic [dispatch_pkg::SLOT_W-1:0] slot1_i,

    // Merged free status and slot reservations
    output logic                          warp_free_o,
    output logic                          grant0_o,
    output logic                          grant1_o,

    // Where the presented block lands
    output logic                          cluster_o,
    output logic [dispatch_pkg::SLOT_W-1:0] slot_o
);

    // ########################################
    // Signals
    // ########################################

    // Cluster that took the previous block
    logic last_q;

    // Chosen cluster for this cycle
    logic sel;

    // Block actually handed to a pool
    logic take;

    // ########################################
    // Selection
    // ########################################

    // Alternate when both pools are free, else the only free one
    always_comb begin : choose
        if (free0_i && free1_i) begin
            sel = ~last_q;
        end else begin
            sel = free1_i;
        end
    end : choose

    assign warp_free_o = free0_i | free1_i;
    assign take        = allocate_i & warp_free_o;

    // At most one grant per cycle
    assign grant0_o = take & ~sel;
    assign grant1_o = take & sel;

    assign cluster_o = sel;
    assign slot_o    = sel ? slot1_i : slot0_i;

    // Cluster 1 counts as last after reset so cluster 0 goes first
    always_ff @(posedge clk_i or negedge rst_n_i) begin : last_reg
        if (!rst_n_i) begin
            last_q <= 1'b1;
        end else if (take) begin
            last_q <= sel;
        end
    end : last_reg

endmodule : cluster_select

// File: design/dispatch_top.sv
/*
 * Top level of the dispatch subsystem.
 * Connects the thread dispatcher, two warp pools and the cluster selector.
 */
`timescale 1ns/1ps

module dispatch_top (
    // Clock and reset
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    // Launch request from the host
    input  logic                                start_i,
    input  logic [dispatch_pkg::PC_W-1:0]         pc_i,
    input  logic [dispatch_pkg::ADDR_W-1:0]       dp_addr_i,
    input  logic [dispatch_pkg::TBLOCK_IDX_W-1:0] number_of_tblocks_i,
    input  logic [dispatch_pkg::TBLOCK_ID_W-1:0]  tblock_id_i,
    output logic                                ready_o,

    // Warp completion per cluster
    input  logic                                warp_done0_i,
    input  logic [dispatch_pkg::SLOT_W-1:0]       done_slot0_i,
    input  logic                                warp_done1_i,
    input  logic [dispatch_pkg::SLOT_W-1:0]       done_slot1_i,

    // Dispatched block
    output logic                                dispatch_valid_o,
    output logic                                dispatch_cluster_o,
    output logic [dispatch_pkg::SLOT_W-1:0]       dispatch_slot_o,
    output logic [dispatch_pkg::PC_W-1:0]         dispatch_pc_o,
    output logic [dispatch_pkg::ADDR_W-1:0]       dispatch_dp_addr_o,
    output logic [dispatch_pkg::TBLOCK_IDX_W-1:0] dispatch_tblock_idx_o,
    output logic [dispatch_pkg::TBLOCK_ID_W-1:0]  dispatch_tblock_id_o
);

    import dispatch_pkg::*;

    // ########################################
    // Internal nets
    // ########################################

    // Dispatcher and selector
    logic              allocate_warp;
    logic              warp_free;

    // Pool status and grants
    logic              free0;
    logic              free1;
    logic [SLOT_W-1:0] slot0;
    logic [SLOT_W-1:0] slot1;
    logic              grant0;
    logic              grant1;

    // A block leaves whenever either pool is granted
    assign dispatch_valid_o = grant0 | grant1;

    // ########################################
    // Instances
    // ########################################

    // Fields pass straight through and hold under back-pressure
    thread_dispatcher i_thread_dispatcher (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .ready_o               (ready_o),
        .start_i               (start_i),
        .pc_i                  (pc_i),
        .dp_addr_i             (dp_addr_i),
        .number_of_tblocks_i   (number_of_tblocks_i),
        .tblock_id_i           (tblock_id_i),
        .warp_free_i           (warp_free),
        .allocate_warp_o       (allocate_warp),
        .allocate_pc_o         (dispatch_pc_o),
        .allocate_dp_addr_o    (dispatch_dp_addr_o),
        .allocate_tblock_idx_o (dispatch_tblock_idx_o),
        .allocate_tblock_id_o  (dispatch_tblock_id_o)
    );

    // Cluster 0
    warp_pool i_warp_pool0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .grant_i     (grant0),
        .done_i      (warp_done0_i),
        .done_slot_i (done_slot0_i),
        .free_o      (free0),
        .slot_o      (slot0)
    );

    // Cluster 1
    warp_pool i_warp_pool1 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .grant_i     (grant1),
        .done_i      (warp_done1_i),
        .done_slot_i (done_slot1_i),
        .free_o      (free1),
        .slot_o      (slot1)
    );

    cluster_select i_cluster_select (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .allocate_i  (allocate_warp),
        .free0_i     (free0),
        .slot0_i     (slot0),
        .free1_i     (free1),
        .slot1_i     (slot1),
        .warp_free_o (warp_free),
        .grant0_o    (grant0),
        .grant1_o    (grant1),
        .cluster_o   (dispatch_cluster_o),
        .slot_o      (dispatch_slot_o)
    );

endmodule : dispatch_top

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock of 4 ns and an active-low reset held for the first two cycles.
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 250 MHz free-running clock
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

    // Release just after the second rising edge, away from any clock edge
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

// File: verif/tb_dispatch_top.sv
/*
 * Directed and random tests of the thread-block dispatch subsystem.
 * A slot-occupancy model predicts the landing cluster and slot of every block.
 */
`timescale 1ns/1ps

module tb_dispatch_top;

    import dispatch_pkg::*;

    // DUT inputs
    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic [PC_W-1:0]         pc;
    logic [ADDR_W-1:0]       dp_addr;
    logic [TBLOCK_IDX_W-1:0] n_blocks;
    logic [TBLOCK_ID_W-1:0]  tblock_id;
    logic                    done0;
    logic [SLOT_W-1:0]       done_slot0;
    logic                    done1;
    logic [SLOT_W-1:0]       done_slot1;

    // Request fields applied together with the next start pulse
    logic [PC_W-1:0]         req_pc;
    logic [ADDR_W-1:0]       req_addr;
    logic [TBLOCK_IDX_W-1:0] req_count;
    logic [TBLOCK_ID_W-1:0]  req_id;

    // DUT outputs
    logic                    ready;
    logic                    valid;
    logic                    cluster;
    logic [SLOT_W-1:0]       slot;
    logic [PC_W-1:0]         out_pc;
    logic [ADDR_W-1:0]       out_addr;
    logic [TBLOCK_IDX_W-1:0] out_idx;
    logic [TBLOCK_ID_W-1:0]  out_id;

    // Reference model of busy slots, last granted cluster and current request
    logic [WARPS_PER_CLUSTER-1:0] busy_m [2];
    logic                         last_m;
    logic [PC_W-1:0]              m_pc;
    logic [ADDR_W-1:0]            m_addr;
    logic [TBLOCK_ID_W-1:0]       m_id;
    logic [TBLOCK_IDX_W-1:0]      m_count;
    logic [TBLOCK_IDX_W-1:0]      m_next;

    // Landing of each dispatched block in the running test
    logic                    log_cluster [$];
    logic [SLOT_W-1:0]       log_slot [$];

    logic [31:0]             rng;
    int                      errors;
    int                      timeouts;
    int                      n;

    tb_clock_gen i_tb_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

    dispatch_top i_dispatch_top (
        .clk_i                 (clk),
        .rst_n_i               (rst_n),
        .start_i               (start),
        .pc_i                  (pc),
        .dp_addr_i             (dp_addr),
        .number_of_tblocks_i   (n_blocks),
        .tblock_id_i           (tblock_id),
        .ready_o               (ready),
        .warp_done0_i          (done0),
        .done_slot0_i          (done_slot0),
        .warp_done1_i          (done1),
        .done_slot1_i          (done_slot1),
        .dispatch_valid_o      (valid),
        .dispatch_cluster_o    (cluster),
        .dispatch_slot_o       (slot),
        .dispatch_pc_o         (out_pc),
        .dispatch_dp_addr_o    (out_addr),
        .dispatch_tblock_idx_o (out_idx),
        .dispatch_tblock_id_o  (out_id)
    );

    // ########################################
    // Helpers and compare tasks
    // ########################################

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report(input string name, input logic [63:0] got, input logic [63:0] exp);
        errors++;
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    endtask

    task automatic check_pc(input string name, input logic [PC_W-1:0] got, exp);
        if (got !== exp) report(name, 64'(got), 64'(exp));
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got, exp);
        if (got !== exp) report(name, 64'(got), 64'(exp));
    endtask

    task automatic check_idx(input string name, input logic [TBLOCK_IDX_W-1:0] got, exp);
        if (got !== exp) report(name, 64'(got), 64'(exp));
    endtask

    task automatic check_id(input string name, input logic [TBLOCK_ID_W-1:0] got, exp);
        if (got !== exp) report(name, 64'(got), 64'(exp));
    endtask

    task automatic check_slot(input string name, input logic [SLOT_W-1:0] got, exp);
        if (got !== exp) report(name, 64'(got), 64'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) report(name, 64'(got), 64'(exp));
    endtask

    // Lowest clear bit of a busy table
    task automatic lowest_free(input logic [WARPS_PER_CLUSTER-1:0] busy,
                               output logic free, output logic [SLOT_W-1:0] idx);
        free = 1'b0;
        idx  = '0;
        for (int i = 0; i < WARPS_PER_CLUSTER; i++) begin
            if (!busy[i] && !free) begin
                free = 1'b1;
                idx  = SLOT_W'(i);
            end
        end
    endtask

    // Drive one cycle on the falling edge and check once outputs settle
    task automatic cycle(input logic go, input logic d0, input logic [SLOT_W-1:0] s0,
                         input logic d1, input logic [SLOT_W-1:0] s1);
        logic              f0;
        logic              f1;
        logic [SLOT_W-1:0] sl0;
        logic [SLOT_W-1:0] sl1;
        logic              present;
        logic              take;
        logic              sel;
        logic [SLOT_W-1:0] exp_slot;
        @(negedge clk);
        start      = go;
        if (go) begin
            pc        = req_pc;
            dp_addr   = req_addr;
            n_blocks  = req_count;
            tblock_id = req_id;
        end
        done0      = d0;
        done_slot0 = s0;
        done1      = d1;
        done_slot1 = s1;
        #1;
        check_bit("ready_o", ready, m_next == m_count);
        // Request captured only while idle
        if (m_next == m_count && go) begin
            m_pc    = pc;
            m_addr  = dp_addr;
            m_id    = tblock_id;
            m_count = n_blocks;
            m_next  = '0;
        end
        present = (m_next != m_count);
        lowest_free(busy_m[0], f0, sl0);
        lowest_free(busy_m[1], f1, sl1);
        take     = present && (f0 || f1);
        // Round robin when both free, else the only free cluster
        sel      = (f0 && f1) ? !last_m : f1;
        exp_slot = sel ? sl1 : sl0;
        check_bit("dispatch_valid_o", valid, take);
        // Fields hold while a block waits and are zero with nothing presented
        check_pc("dispatch_pc_o", out_pc, present ? m_pc : '0);
        check_addr("dispatch_dp_addr_o", out_addr, present ? m_addr : '0);
        check_idx("dispatch_tblock_idx_o", out_idx, present ? m_next : '0);
        check_id("dispatch_tblock_id_o", out_id, present ? m_id : '0);
        if (take) begin
            check_bit("dispatch_cluster_o", cluster, sel);
            check_slot("dispatch_slot_o", slot, exp_slot);
        end
        if (valid) begin
            log_cluster.push_back(cluster);
            log_slot.push_back(slot);
        end
        // Clear before set so a grant wins over a done on the same slot
        if (d0) busy_m[0][s0] = 1'b0;
        if (d1) busy_m[1][s1] = 1'b0;
        if (take) begin
            busy_m[sel][exp_slot] = 1'b1;
            last_m = sel;
            m_next = m_next + TBLOCK_IDX_W'(1);
        end
    endtask

    task automatic launch(input int cnt, input logic [TBLOCK_ID_W-1:0] id,
                          input logic [PC_W-1:0] p, input logic [ADDR_W-1:0] a);
        req_count = TBLOCK_IDX_W'(cnt);
        req_id    = id;
        req_pc    = p;
        req_addr  = a;
        cycle(1'b1, 1'b0, '0, 1'b0, '0);
    endtask

    // Run idle cycles with optional random done pulses until ready_o returns
    task automatic wait_ready(input int limit, input logic rand_done);
        logic [31:0] r;
        int          k;
        r = '0;
        for (k = 0; k < limit; k++) begin
            if (rand_done) begin
                rng = xorshift(rng);
                r   = rng;
            end
            cycle(1'b0, r[0] & r[1], SLOT_W'(r >> 2), r[4] & r[5], SLOT_W'(r >> 6));
            if (ready) break;
        end
        if (k == limit) begin
            timeouts++;
            $display("Timeout: ready_o did not return within %0d cycles", limit);
        end
    endtask

    // Pulse done for every slot the model holds busy
    task automatic free_all();
        for (int s = 0; s < WARPS_PER_CLUSTER; s++) begin
            cycle(1'b0, busy_m[0][s], SLOT_W'(s), busy_m[1][s], SLOT_W'(s));
        end
    endtask

    task automatic check_landing(input int k, input logic c, input logic [SLOT_W-1:0] s);
        if (k >= log_cluster.size()) begin
            errors++;
            $display("Block %0d of the test was never dispatched", k);
        end else begin
            check_bit("dispatch_cluster_o", log_cluster[k], c);
            check_slot("dispatch_slot_o", log_slot[k], s);
        end
    endtask

    // ########################################
    // Tests
    // ########################################

    task automatic test_reset();
        cycle(1'b0, 1'b0, '0, 1'b0, '0);
        check_bit("ready_o", ready, 1'b1);
        check_bit("dispatch_valid_o", valid, 1'b0);
    endtask

    task automatic test_small_group();
        log_cluster.delete();
        log_slot.delete();
        launch(3, 8'h11, 16'h0100, 32'h1000_0000);
        wait_ready(10, 1'b0);
        // Cluster 0 first and then alternating
        check_landing(0, 1'b0, SLOT_W'(0));
        check_landing(1, 1'b1, SLOT_W'(0));
        check_landing(2, 1'b0, SLOT_W'(1));
    endtask

    task automatic test_back_pressure();
        free_all();
        log_cluster.delete();
        log_slot.delete();
        launch(10, 8'h22, 16'h0200, 32'h2000_0040);
        // Blocks 1 to 7 fill the remaining slots one per cycle
        repeat (7) cycle(1'b0, 1'b0, '0, 1'b0, '0);
        // All slots busy so block 8 waits
        repeat (3) cycle(1'b0, 1'b0, '0, 1'b0, '0);
        check_bit("ready_o", ready, 1'b0);
        cycle(1'b0, 1'b0, '0, 1'b1, SLOT_W'(2));
        cycle(1'b0, 1'b1, SLOT_W'(1), 1'b0, '0);
        wait_ready(10, 1'b0);
        check_landing(8, 1'b1, SLOT_W'(2));
        check_landing(9, 1'b0, SLOT_W'(1));
    endtask

    task automatic test_zero_count();
        // Free slots so a wrongly presented block would be taken
        free_all();
        launch(0, 8'h33, 16'h0300, 32'h3000_0000);
        repeat (2) cycle(1'b0, 1'b0, '0, 1'b0, '0);
        check_bit("ready_o", ready, 1'b1);
    endtask

    task automatic test_stray_done();
        free_all();
        launch(2, 8'h44, 16'h0400, 32'h4000_0080);
        wait_ready(10, 1'b0);
        // Done on idle slots must leave the busy table alone
        for (int s = 0; s < WARPS_PER_CLUSTER; s++) begin
            cycle(1'b0, !busy_m[0][s], SLOT_W'(s), !busy_m[1][s], SLOT_W'(s));
        end
        launch(3, 8'h45, 16'h0480, 32'h4000_0100);
        wait_ready(10, 1'b0);
    endtask

    task automatic test_random();
        for (int g = 0; g < 20; g++) begin
            rng = xorshift(rng);
            launch(int'(rng % 12) + 1, TBLOCK_ID_W'(rng >> 8), PC_W'(rng >> 4), xorshift(rng));
            wait_ready(200, 1'b1);
        end
    endtask

    initial begin
        rng        = 32'h64eb_2a5a;
        errors     = 0;
        timeouts   = 0;
        start      = 1'b0;
        pc         = '0;
        dp_addr    = '0;
        n_blocks   = '0;
        tblock_id  = '0;
        done0      = 1'b0;
        done_slot0 = '0;
        done1      = 1'b0;
        done_slot1 = '0;
        req_pc     = '0;
        req_addr   = '0;
        req_count  = '0;
        req_id     = '0;
        busy_m[0]  = '0;
        busy_m[1]  = '0;
        last_m     = 1'b1;
        m_pc       = '0;
        m_addr     = '0;
        m_id       = '0;
        m_count    = '0;
        m_next     = '0;

        for (n = 0; n < 20 && !rst_n; n++) @(negedge clk);
        if (!rst_n) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end

        test_reset();
        test_small_group();
        test_back_pressure();
        test_zero_count();
        test_stray_done();
        test_random();

        $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_dispatch_top

// File: all.f
design/dispatch_pkg.sv
design/thread_dispatcher.sv
design/warp_pool.sv
design/cluster_select.sv
design/dispatch_top.sv
verif/tb_clock_gen.sv
verif/tb_dispatch_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_dispatch_top -f all.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
